// ==== id_pkg.sv ====
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;
    localparam int ALUSEL_W   = 3;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for loads, stores and branches
    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;
    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB / SRA / SRAI

    localparam logic [ALUOP_W-1:0] ALU_NOP  = 8'h00;
    localparam logic [ALUOP_W-1:0] ALU_ADD  = 8'h01;
    localparam logic [ALUOP_W-1:0] ALU_SUB  = 8'h02;
    localparam logic [ALUOP_W-1:0] ALU_SLT  = 8'h03;
    localparam logic [ALUOP_W-1:0] ALU_SLTU = 8'h04;
    localparam logic [ALUOP_W-1:0] ALU_AND  = 8'h05;
    localparam logic [ALUOP_W-1:0] ALU_OR   = 8'h06;
    localparam logic [ALUOP_W-1:0] ALU_XOR  = 8'h07;
    localparam logic [ALUOP_W-1:0] ALU_SLL  = 8'h08;
    localparam logic [ALUOP_W-1:0] ALU_SRL  = 8'h09;
    localparam logic [ALUOP_W-1:0] ALU_SRA  = 8'h0a;
    localparam logic [ALUOP_W-1:0] ALU_LB   = 8'h10;
    localparam logic [ALUOP_W-1:0] ALU_LH   = 8'h11;
    localparam logic [ALUOP_W-1:0] ALU_LW   = 8'h12;
    localparam logic [ALUOP_W-1:0] ALU_LBU  = 8'h13;
    localparam logic [ALUOP_W-1:0] ALU_LHU  = 8'h14;
    localparam logic [ALUOP_W-1:0] ALU_SB   = 8'h18;
    localparam logic [ALUOP_W-1:0] ALU_SH   = 8'h19;
    localparam logic [ALUOP_W-1:0] ALU_SW   = 8'h1a;
    localparam logic [ALUOP_W-1:0] ALU_BEQ  = 8'h20;
    localparam logic [ALUOP_W-1:0] ALU_BNE  = 8'h21;
    localparam logic [ALUOP_W-1:0] ALU_BLT  = 8'h22;
    localparam logic [ALUOP_W-1:0] ALU_BGE  = 8'h23;
    localparam logic [ALUOP_W-1:0] ALU_BLTU = 8'h24;
    localparam logic [ALUOP_W-1:0] ALU_BGEU = 8'h25;
    localparam logic [ALUOP_W-1:0] ALU_JAL  = 8'h30;
    localparam logic [ALUOP_W-1:0] ALU_JALR = 8'h31;

    localparam logic [ALUSEL_W-1:0] SEL_NOP   = 3'd0;
    localparam logic [ALUSEL_W-1:0] SEL_LOGIC = 3'd1;
    localparam logic [ALUSEL_W-1:0] SEL_SHIFT = 3'd2;
    localparam logic [ALUSEL_W-1:0] SEL_ARITH = 3'd3;
    localparam logic [ALUSEL_W-1:0] SEL_LDST  = 3'd4;
    localparam logic [ALUSEL_W-1:0] SEL_JUMP  = 3'd5;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word seen in every format at once
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

endpackage

// ==== inst_decoder.sv ====
module inst_decoder
    import id_pkg::*;
(
    input  logic [XLEN-1:0]       pc_i,
    input  inst_t                 inst_i,
    input  logic                  inst_valid_i,
    output logic [ALUOP_W-1:0]    aluop_o,
    output logic [ALUSEL_W-1:0]   alusel_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output logic                  wreg_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  jump_o,
    output logic [XLEN-1:0]       jump_target_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_op;
    logic            is_shift;
    logic            alt;
    logic            known;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] shamt;

    assign opcode   = inst_i.r_fmt.opcode;
    assign funct3   = inst_i.r_fmt.funct3;
    assign funct7   = inst_i.r_fmt.funct7;
    assign is_op    = (opcode == OPC_OP);
    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);
    assign alt      = (funct7 == F7_ALT);

    assign i_imm = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign s_imm = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
    assign b_imm = {{19{inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm12, inst_i.b_fmt.imm11,
                    inst_i.b_fmt.imm10_5, inst_i.b_fmt.imm4_1, 1'b0};
    assign u_imm = {inst_i.u_fmt.imm, 12'b0};
    assign j_imm = {{11{inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm20, inst_i.j_fmt.imm19_12,
                    inst_i.j_fmt.imm11, inst_i.j_fmt.imm10_1, 1'b0};
    assign shamt = {{(XLEN-REG_ADDR_W){1'b0}}, inst_i.r_fmt.rs2};  // zero-extended

    always_comb begin
        known       = 1'b1;
        aluop_o     = ALU_NOP;
        alusel_o    = SEL_NOP;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        wreg_o      = 1'b0;
        imm_o       = '0;
        case (opcode)
            OPC_LOAD: begin
                alusel_o    = SEL_LDST;
                reg1_read_o = 1'b1;
                wreg_o      = 1'b1;
                imm_o       = i_imm;
                case (funct3)
                    F3_LB:   aluop_o = ALU_LB;
                    F3_LH:   aluop_o = ALU_LH;
                    F3_LW:   aluop_o = ALU_LW;
                    F3_LBU:  aluop_o = ALU_LBU;
                    F3_LHU:  aluop_o = ALU_LHU;
                    default: known = 1'b0;
                endcase
            end
            OPC_STORE: begin
                alusel_o    = SEL_LDST;
                reg1_read_o = 1'b1;
                reg2_read_o = 1'b1;
                imm_o       = s_imm;
                case (funct3)
                    F3_SB:   aluop_o = ALU_SB;
                    F3_SH:   aluop_o = ALU_SH;
                    F3_SW:   aluop_o = ALU_SW;
                    default: known = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                reg1_read_o = 1'b1;  // resolved in EX
                reg2_read_o = 1'b1;
                imm_o       = b_imm;
                case (funct3)
                    F3_BEQ:  aluop_o = ALU_BEQ;
                    F3_BNE:  aluop_o = ALU_BNE;
                    F3_BLT:  aluop_o = ALU_BLT;
                    F3_BGE:  aluop_o = ALU_BGE;
                    F3_BLTU: aluop_o = ALU_BLTU;
                    F3_BGEU: aluop_o = ALU_BGEU;
                    default: known = 1'b0;
                endcase
            end
            OPC_JAL: begin
                aluop_o  = ALU_JAL;
                alusel_o = SEL_JUMP;
                wreg_o   = 1'b1;
                imm_o    = j_imm;
            end
            OPC_JALR: begin
                aluop_o     = ALU_JALR;
                alusel_o    = SEL_JUMP;
                reg1_read_o = 1'b1;
                wreg_o      = 1'b1;
                imm_o       = i_imm;
            end
            OPC_LUI: begin
                aluop_o  = ALU_OR;  // imm | imm
                alusel_o = SEL_LOGIC;
                wreg_o   = 1'b1;
                imm_o    = u_imm;
            end
            OPC_OP, OPC_OPIMM: begin
                reg1_read_o = 1'b1;
                reg2_read_o = is_op;
                wreg_o      = 1'b1;
                imm_o       = is_op ? '0 : (is_shift ? shamt : i_imm);
                case (funct3)
                    F3_ADD_SUB: begin
                        aluop_o  = (is_op && alt) ? ALU_SUB : ALU_ADD;
                        alusel_o = SEL_ARITH;
                    end
                    F3_SLT: begin
                        aluop_o  = ALU_SLT;
                        alusel_o = SEL_ARITH;
                    end
                    F3_SLTU: begin
                        aluop_o  = ALU_SLTU;
                        alusel_o = SEL_ARITH;
                    end
                    F3_XOR: begin
                        aluop_o  = ALU_XOR;
                        alusel_o = SEL_LOGIC;
                    end
                    F3_OR: begin
                        aluop_o  = ALU_OR;
                        alusel_o = SEL_LOGIC;
                    end
                    F3_AND: begin
                        aluop_o  = ALU_AND;
                        alusel_o = SEL_LOGIC;
                    end
                    F3_SLL: begin
                        aluop_o  = ALU_SLL;
                        alusel_o = SEL_SHIFT;
                    end
                    F3_SRL_SRA: begin
                        aluop_o  = alt ? ALU_SRA : ALU_SRL;
                        alusel_o = SEL_SHIFT;
                    end
                endcase
                // funct7 only meaningful for OP and the immediate shifts
                if (is_op || is_shift) begin
                    known = (funct7 == F7_BASE) ||
                            (alt && ((funct3 == F3_SRL_SRA) || (is_op && funct3 == F3_ADD_SUB)));
                end
            end
            default: known = 1'b0;
        endcase
        if (!known) begin  // unknown encoding becomes a NOP
            aluop_o     = ALU_NOP;
            alusel_o    = SEL_NOP;
            reg1_read_o = 1'b0;
            reg2_read_o = 1'b0;
            wreg_o      = 1'b0;
            imm_o       = '0;
        end
    end

    assign rs1_o = reg1_read_o ? inst_i.r_fmt.rs1 : '0;
    assign rs2_o = reg2_read_o ? inst_i.r_fmt.rs2 : '0;
    assign rd_o  = wreg_o ? inst_i.r_fmt.rd : '0;

    assign jump_o        = inst_valid_i && (aluop_o == ALU_JAL);
    assign jump_target_o = pc_i + j_imm;

endmodule

// ==== operand_forward.sv ====
module operand_forward
    import id_pkg::*;
(
    input  logic                  rd_en_i,
    input  logic [REG_ADDR_W-1:0] rs_addr_i,
    input  logic [XLEN-1:0]       rf_data_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic                  ex_wreg_i,
    input  logic                  ex_load_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [XLEN-1:0]       ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [XLEN-1:0]       mem_wdata_i,
    output logic [XLEN-1:0]       operand_o,
    output logic                  hazard_o
);

    logic live;
    logic ex_hit;
    logic mem_hit;

    assign live    = rd_en_i && (rs_addr_i != '0);  // x0 never matches
    assign ex_hit  = live && ex_wreg_i && (rs_addr_i == ex_wd_i);
    assign mem_hit = live && mem_wreg_i && (rs_addr_i == mem_wd_i);

    // load data not ready until MEM
    assign hazard_o = ex_hit && ex_load_i;

    always_comb begin
        if (!rd_en_i) begin
            operand_o = imm_i;
        end else if (hazard_o) begin
            operand_o = '0;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

// ==== id_ex_reg.sv ====
module id_ex_reg
    import id_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  logic                  hazard1_i,
    input  logic                  hazard2_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [ALUOP_W-1:0]    aluop_i,
    input  logic [ALUSEL_W-1:0]   alusel_i,
    input  logic [XLEN-1:0]       op1_i,
    input  logic [XLEN-1:0]       op2_i,
    input  logic [XLEN-1:0]       offset_i,
    input  logic [REG_ADDR_W-1:0] wd_i,
    input  logic                  wreg_i,
    output logic                  stall_o,
    output logic                  ex_valid_o,
    output logic                  ex_load_o,
    output logic [XLEN-1:0]       ex_pc_o,
    output logic [ALUOP_W-1:0]    ex_aluop_o,
    output logic [ALUSEL_W-1:0]   ex_alusel_o,
    output logic [XLEN-1:0]       ex_op1_o,
    output logic [XLEN-1:0]       ex_op2_o,
    output logic [XLEN-1:0]       ex_offset_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_wreg_o
);

    logic accept;

    assign stall_o = inst_valid_i && (hazard1_i || hazard2_i);
    assign accept  = inst_valid_i && !stall_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o  <= 1'b0;
            ex_load_o   <= 1'b0;
            ex_wreg_o   <= 1'b0;
            ex_aluop_o  <= ALU_NOP;
            ex_alusel_o <= SEL_NOP;
            ex_pc_o     <= '0;
            ex_op1_o    <= '0;
            ex_op2_o    <= '0;
            ex_offset_o <= '0;
            ex_wd_o     <= '0;
        end else begin  // bubble unless accepted
            ex_valid_o  <= accept;
            ex_load_o   <= accept && wreg_i && (alusel_i == SEL_LDST);
            ex_wreg_o   <= accept && wreg_i;
            ex_aluop_o  <= accept ? aluop_i : ALU_NOP;
            ex_alusel_o <= accept ? alusel_i : SEL_NOP;
            ex_pc_o     <= accept ? pc_i : '0;
            ex_op1_o    <= accept ? op1_i : '0;
            ex_op2_o    <= accept ? op2_i : '0;
            ex_offset_o <= accept ? offset_i : '0;
            ex_wd_o     <= accept ? wd_i : '0;
        end
    end

endmodule

// ==== id_stage.sv ====
module id_stage
    import id_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       pc_i,
    input  inst_t                 inst_i,
    input  logic                  inst_valid_i,
    input  logic [XLEN-1:0]       reg1_data_i,
    input  logic [XLEN-1:0]       reg2_data_i,
    input  logic [XLEN-1:0]       ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [XLEN-1:0]       mem_wdata_i,
    output logic [REG_ADDR_W-1:0] reg1_addr_o,
    output logic [REG_ADDR_W-1:0] reg2_addr_o,
    output logic                  stall_o,
    output logic                  jump_o,
    output logic [XLEN-1:0]       jump_target_o,
    output logic                  ex_valid_o,
    output logic [XLEN-1:0]       ex_pc_o,
    output logic [ALUOP_W-1:0]    ex_aluop_o,
    output logic [ALUSEL_W-1:0]   ex_alusel_o,
    output logic [XLEN-1:0]       ex_op1_o,
    output logic [XLEN-1:0]       ex_op2_o,
    output logic [XLEN-1:0]       ex_offset_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_wreg_o
);

    logic [ALUOP_W-1:0]    aluop;
    logic [ALUSEL_W-1:0]   alusel;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg1_read;
    logic                  reg2_read;
    logic                  wreg;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic                  hazard1;
    logic                  hazard2;
    logic                  ex_load;  // load sitting in EX

    inst_decoder u_dec (
        .pc_i          (pc_i),
        .inst_i        (inst_i),
        .inst_valid_i  (inst_valid_i),
        .aluop_o       (aluop),
        .alusel_o      (alusel),
        .rs1_o         (reg1_addr_o),
        .rs2_o         (reg2_addr_o),
        .rd_o          (rd),
        .reg1_read_o   (reg1_read),
        .reg2_read_o   (reg2_read),
        .wreg_o        (wreg),
        .imm_o         (imm),
        .jump_o        (jump_o),
        .jump_target_o (jump_target_o)
    );

    operand_forward u_fwd1 (
        .rd_en_i     (reg1_read),
        .rs_addr_i   (reg1_addr_o),
        .rf_data_i   (reg1_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_o),
        .ex_load_i   (ex_load),
        .ex_wd_i     (ex_wd_o),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (op1),
        .hazard_o    (hazard1)
    );

    operand_forward u_fwd2 (
        .rd_en_i     (reg2_read),
        .rs_addr_i   (reg2_addr_o),
        .rf_data_i   (reg2_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_o),
        .ex_load_i   (ex_load),
        .ex_wd_i     (ex_wd_o),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (op2),
        .hazard_o    (hazard2)
    );

    id_ex_reg u_idex (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .hazard1_i    (hazard1),
        .hazard2_i    (hazard2),
        .pc_i         (pc_i),
        .aluop_i      (aluop),
        .alusel_i     (alusel),
        .op1_i        (op1),
        .op2_i        (op2),
        .offset_i     (imm),
        .wd_i         (rd),
        .wreg_i       (wreg),
        .stall_o      (stall_o),
        .ex_valid_o   (ex_valid_o),
        .ex_load_o    (ex_load),
        .ex_pc_o      (ex_pc_o),
        .ex_aluop_o   (ex_aluop_o),
        .ex_alusel_o  (ex_alusel_o),
        .ex_op1_o     (ex_op1_o),
        .ex_op2_o     (ex_op2_o),
        .ex_offset_o  (ex_offset_o),
        .ex_wd_o      (ex_wd_o),
        .ex_wreg_o    (ex_wreg_o)
    );

endmodule

// ==== tb_id_stage.sv ====
module tb_id_stage
    import id_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 64;
    localparam int NFIELD  = 19;
    // column index in a vector line
    localparam int C_TEST   = 0;
    localparam int C_PC     = 1;
    localparam int C_INST   = 2;
    localparam int C_VALID  = 3;
    localparam int C_EXWD   = 4;
    localparam int C_MWREG  = 5;
    localparam int C_MWD    = 6;
    localparam int C_MWDATA = 7;
    localparam int C_STALL  = 8;
    localparam int C_JUMP   = 9;
    localparam int C_JTGT   = 10;
    localparam int C_EVALID = 11;
    localparam int C_ALUOP  = 12;
    localparam int C_ALUSEL = 13;
    localparam int C_OP1    = 14;
    localparam int C_OP2    = 15;
    localparam int C_OFFSET = 16;
    localparam int C_WD     = 17;
    localparam int C_WREG   = 18;

    logic                  clk_i;
    logic                  rst_n_i;
    logic [XLEN-1:0]       pc_i;
    inst_t                 inst_i;
    logic                  inst_valid_i;
    logic [XLEN-1:0]       reg1_data_i;
    logic [XLEN-1:0]       reg2_data_i;
    logic [XLEN-1:0]       ex_wdata_i;
    logic                  mem_wreg_i;
    logic [REG_ADDR_W-1:0] mem_wd_i;
    logic [XLEN-1:0]       mem_wdata_i;
    logic [REG_ADDR_W-1:0] reg1_addr_o;
    logic [REG_ADDR_W-1:0] reg2_addr_o;
    logic                  stall_o;
    logic                  jump_o;
    logic [XLEN-1:0]       jump_target_o;
    logic                  ex_valid_o;
    logic [XLEN-1:0]       ex_pc_o;
    logic [ALUOP_W-1:0]    ex_aluop_o;
    logic [ALUSEL_W-1:0]   ex_alusel_o;
    logic [XLEN-1:0]       ex_op1_o;
    logic [XLEN-1:0]       ex_op2_o;
    logic [XLEN-1:0]       ex_offset_o;
    logic [REG_ADDR_W-1:0] ex_wd_o;
    logic                  ex_wreg_o;

    logic [31:0] vec [MAX_VEC][NFIELD];
    int          nvec;
    int          errors;
    int          cycles;
    int          cycle_limit;
    int          seed;

    id_stage dut (.*);

    always #2 clk_i = ~clk_i;

    // xk reads 0x1000_0000 + k and x0 reads zero
    assign reg1_data_i = (reg1_addr_o == '0) ? '0 : 32'h1000_0000 + 32'(reg1_addr_o);
    assign reg2_data_i = (reg2_addr_o == '0) ? '0 : 32'h1000_0000 + 32'(reg2_addr_o);

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: no end of run after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // zero when the operand is not read by this opcode
    function automatic logic [REG_ADDR_W-1:0] expected_raddr(input logic [31:0] inst,
                                                             input bit second);
        logic [6:0]            opc;
        logic                  reads;
        logic [REG_ADDR_W-1:0] addr;
        opc = inst[6:0];
        if (second) begin
            reads = (opc == OPC_STORE) || (opc == OPC_BRANCH) || (opc == OPC_OP);
            addr  = inst[24:20];
        end else begin
            reads = (opc == OPC_LOAD) || (opc == OPC_STORE) || (opc == OPC_BRANCH) ||
                    (opc == OPC_JALR) || (opc == OPC_OP) || (opc == OPC_OPIMM);
            addr  = inst[19:15];
        end
        return reads ? addr : '0;
    endfunction

    task automatic read_vectors();
        int    fd;
        int    cnt;
        int    r;
        string line;
        fd = $fopen("id_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open id_stimulus.txt");
        end else begin
            while (!$feof(fd) && nvec < MAX_VEC) begin
                r = $fgets(line, fd);
                if (r != 0 && line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec[nvec][0], vec[nvec][1], vec[nvec][2], vec[nvec][3],
                        vec[nvec][4], vec[nvec][5], vec[nvec][6], vec[nvec][7],
                        vec[nvec][8], vec[nvec][9], vec[nvec][10], vec[nvec][11],
                        vec[nvec][12], vec[nvec][13], vec[nvec][14], vec[nvec][15],
                        vec[nvec][16], vec[nvec][17], vec[nvec][18]);
                    if (cnt == NFIELD) begin
                        nvec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_vector(input int i);
        pc_i         = vec[i][C_PC];
        inst_i       = vec[i][C_INST];
        inst_valid_i = vec[i][C_VALID][0];
        ex_wdata_i   = vec[i][C_EXWD];
        mem_wreg_i   = vec[i][C_MWREG][0];
        mem_wd_i     = vec[i][C_MWD][REG_ADDR_W-1:0];
        mem_wdata_i  = vec[i][C_MWDATA];
    endtask

    task automatic check_comb(input int i);
        check_val("stall_o", 32'(stall_o), vec[i][C_STALL]);
        check_val("jump_o", 32'(jump_o), vec[i][C_JUMP]);
        if (vec[i][C_JUMP][0]) begin
            check_val("jump_target_o", jump_target_o, vec[i][C_JTGT]);
        end
        check_val("reg1_addr_o", 32'(reg1_addr_o), 32'(expected_raddr(vec[i][C_INST], 1'b0)));
        check_val("reg2_addr_o", 32'(reg2_addr_o), 32'(expected_raddr(vec[i][C_INST], 1'b1)));
    endtask

    task automatic check_regs(input int i);
        logic [31:0] exp_pc;
        exp_pc = vec[i][C_EVALID][0] ? vec[i][C_PC] : 32'h0;  // bubble clears pc
        check_val("ex_valid_o", 32'(ex_valid_o), vec[i][C_EVALID]);
        check_val("ex_pc_o", ex_pc_o, exp_pc);
        check_val("ex_aluop_o", 32'(ex_aluop_o), vec[i][C_ALUOP]);
        check_val("ex_alusel_o", 32'(ex_alusel_o), vec[i][C_ALUSEL]);
        check_val("ex_op1_o", ex_op1_o, vec[i][C_OP1]);
        check_val("ex_op2_o", ex_op2_o, vec[i][C_OP2]);
        check_val("ex_offset_o", ex_offset_o, vec[i][C_OFFSET]);
        check_val("ex_wd_o", 32'(ex_wd_o), vec[i][C_WD]);
        check_val("ex_wreg_o", 32'(ex_wreg_o), vec[i][C_WREG]);
    endtask

    initial begin
        int tests;
        int failed;
        int test_err;
        int gap;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        inst_valid_i = 1'b0;
        ex_wdata_i   = '0;
        mem_wreg_i   = 1'b0;
        mem_wd_i     = '0;
        mem_wdata_i  = '0;
        errors       = 0;
        cycles       = 0;
        cycle_limit  = 1000;
        seed         = 43;
        nvec         = 0;
        tests        = 0;
        failed       = 0;

        read_vectors();
        cycle_limit = 2 * nvec + 20;

        repeat (4) @(posedge clk_i);
        #1;
        check_val("ex_valid_o", 32'(ex_valid_o), 32'h0);  // state under reset
        check_val("ex_wreg_o", 32'(ex_wreg_o), 32'h0);
        check_val("stall_o", 32'(stall_o), 32'h0);
        check_val("ex_aluop_o", 32'(ex_aluop_o), 32'(ALU_NOP));
        tests++;
        if (errors != 0) begin
            failed++;
        end
        $display("test 1 (reset): %0d errors", errors);
        rst_n_i  = 1'b1;
        test_err = errors;

        for (int i = 0; i < nvec; i++) begin
            if (i > 0 && vec[i][C_TEST] != vec[i-1][C_TEST]) begin
                tests++;
                if (errors != test_err) begin
                    failed++;
                end
                $display("test %0d: %0d errors", vec[i-1][C_TEST], errors - test_err);
                test_err = errors;
                gap = {$random(seed)} % 2;  // idle cycles between tests
                repeat (gap) begin
                    inst_valid_i = 1'b0;
                    @(posedge clk_i);
                    #1;
                end
            end
            drive_vector(i);
            #2;
            check_comb(i);
            @(posedge clk_i);
            #1;
            check_regs(i);
        end
        if (nvec > 0) begin
            tests++;
            if (errors != test_err) begin
                failed++;
            end
            $display("test %0d: %0d errors", vec[nvec-1][C_TEST], errors - test_err);
        end else begin
            $display("no vectors read from id_stimulus.txt");
            errors++;
        end
        inst_valid_i = 1'b0;

        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== id_stimulus.txt ====
# test pc inst valid ex_wdata mem_wreg mem_wd mem_wdata | stall jump jump_target
# | ex_valid aluop alusel op1 op2 offset wd wreg   (test decimal, the rest hex)
2 00000100 002081b3 1 0 0 0 0 0 0 0 1 01 3 10000001 10000002 00000000 03 1
2 00000104 40628233 1 0 0 0 0 0 0 0 1 02 3 10000005 10000006 00000000 04 1
2 00000108 009423b3 1 0 0 0 0 0 0 0 1 03 3 10000008 10000009 00000000 07 1
2 0000010c 00c5b533 1 0 0 0 0 0 0 0 1 04 3 1000000b 1000000c 00000000 0a 1
2 00000110 00f776b3 1 0 0 0 0 0 0 0 1 05 1 1000000e 1000000f 00000000 0d 1
2 00000114 0128e833 1 0 0 0 0 0 0 0 1 06 1 10000011 10000012 00000000 10 1
2 00000118 015a49b3 1 0 0 0 0 0 0 0 1 07 1 10000014 10000015 00000000 13 1
2 0000011c 018b9b33 1 0 0 0 0 0 0 0 1 08 2 10000017 10000018 00000000 16 1
2 00000120 41bd5cb3 1 0 0 0 0 0 0 0 1 0a 2 1000001a 1000001b 00000000 19 1
2 00000124 ffb10093 1 0 0 0 0 0 0 0 1 01 3 10000002 fffffffb fffffffb 01 1
2 00000128 0071d113 1 0 0 0 0 0 0 0 1 09 2 10000003 00000007 00000007 02 1
2 0000012c 41f2d213 1 0 0 0 0 0 0 0 1 0a 2 10000005 0000001f 0000001f 04 1
2 00000130 8003b313 1 0 0 0 0 0 0 0 1 04 3 10000007 fffff800 fffff800 06 1
3 00000200 ffc4a403 1 0 0 0 0 0 0 0 1 12 4 10000009 fffffffc fffffffc 08 1
3 00000204 00a5a423 1 0 0 0 0 0 0 0 1 1a 4 1000000b 1000000a 00000008 00 0
3 00000208 fed618e3 1 0 0 0 0 0 0 0 1 21 0 1000000c 1000000d fffffff0 00 0
3 0000020c 12345737 1 0 0 0 0 0 0 0 1 06 1 12345000 12345000 12345000 0e 1
3 00000210 00c780e7 1 0 0 0 0 0 0 0 1 31 5 1000000f 0000000c 0000000c 01 1
4 00001000 100000ef 1 0 0 0 0 0 1 00001100 1 30 5 00000100 00000100 00000100 01 1
4 00002000 ff9ff2ef 1 0 0 0 0 0 1 00001ff8 1 30 5 fffffff8 fffffff8 fffffff8 05 1
5 00000300 00100293 1 0 0 0 0 0 0 0 1 01 3 00000000 00000001 00000001 05 1
5 00000304 00728333 1 aaaa0001 1 07 bbbb0002 0 0 0 1 01 3 aaaa0001 bbbb0002 00000000 06 1
5 00000308 40630433 1 cccc0003 1 06 dddd0004 0 0 0 1 02 3 cccc0003 cccc0003 00000000 08 1
5 0000030c 00508013 1 0 0 0 0 0 0 0 1 01 3 10000001 00000005 00000005 00 1
5 00000310 000004b3 1 eeee0005 1 00 ffff0006 0 0 0 1 01 3 00000000 00000000 00000000 09 1
6 00000400 0005a503 1 0 0 0 0 0 0 0 1 12 4 1000000b 00000000 00000000 0a 1
6 00000404 00d50633 1 0 0 0 0 1 0 0 0 00 0 00000000 00000000 00000000 00 0
6 00000404 00d50633 1 0 1 0a 12340007 0 0 0 1 01 3 12340007 1000000d 00000000 0c 1

// ==== sources.f ====
id_pkg.sv
inst_decoder.sv
operand_forward.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f sources.f --top-module tb_id_stage -o sim_id > build.log 2>&1 \
    && ./obj_dir/sim_id > sim.log 2>&1 \
    || echo "build or run error, see build.log and sim.log"
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
